// ==== include/rs_defaults.svh ====
`ifndef RS_DEFAULTS_SVH
`define RS_DEFAULTS_SVH

// number of station slots when the top is not overridden
// any value of 2 or more works
`define RS_SIZE_DEFAULT 8

// data and tag widths are fixed in rob_tag_pkg
// (DATA_W and ROB_TAG_W)

`endif

// ==== logic/rob_tag_pkg.sv ====
`default_nettype none

package rob_tag_pkg;

  // rob index width
  // the top has no tag parameter, so this constant sizes every tag field
  localparam int ROB_TAG_W = 4;

  // architectural register value width
  localparam int DATA_W = 32;

  // tag and value types shared by the wakeup producers and consumers
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;
  typedef logic [DATA_W-1:0] reg_value_t;

  // one wakeup broadcast
  // the rob commit port and the alu result port both use this shape
  typedef struct packed {
    // broadcast carries a value this cycle
    logic       valid;
    // rob slot being produced
    rob_tag_t   tag;
    // produced register value
    reg_value_t value;
  } rob_bcast_t;

endpackage : rob_tag_pkg

`default_nettype wire

// ==== logic/alu_uop_pkg.sv ====
`default_nettype none

package alu_uop_pkg;

  // alu opcodes, mov passes op2 through
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_ORR = 3'd3,
    OP_EOR = 3'd4,
    OP_MOV = 3'd5
  } alu_op_e;

  // source operand, either a known value or a pending rob tag
  typedef struct packed {
    // value field holds the operand
    logic                    ready;
    // producer tag, only meaningful while not ready
    rob_tag_pkg::rob_tag_t   tag;
    rob_tag_pkg::reg_value_t value;
  } operand_t;

  // decoded alu micro-op from dispatch
  typedef struct packed {
    operand_t              op1;
    operand_t              op2;
    alu_op_e               opcode;
    // rob slot that receives the result
    rob_tag_pkg::rob_tag_t dst_tag;
    // update nzcv with this op
    logic                  set_nzcv;
  } alu_uop_t;

  // one station slot
  typedef struct packed {
    logic     valid;
    alu_uop_t uop;
  } rs_entry_t;

  // registered alu output
  typedef struct packed {
    logic                    valid;
    rob_tag_pkg::rob_tag_t   tag;
    rob_tag_pkg::reg_value_t value;
    logic                    nzcv_valid;
    // n, z, c, v from msb to lsb
    logic [3:0]              nzcv;
  } alu_result_t;

endpackage : alu_uop_pkg

`default_nettype wire

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
  parameter int RS_SIZE = 8
) (
  input  wire logic                    in_clk,
  input  wire logic                    in_rst,
  // dispatch side
  input  wire logic                    in_dispatch_valid,
  input  wire alu_uop_pkg::alu_uop_t   in_dispatch,
  // wakeup sources
  input  wire rob_tag_pkg::rob_bcast_t in_rob_bcast,
  input  wire rob_tag_pkg::rob_bcast_t in_alu_bcast,
  input  wire logic                    in_flush,
  // from the select
  input  wire logic [RS_SIZE-1:0]      in_grant,
  input  wire logic                    in_grant_valid,
  // to the select
  output logic [RS_SIZE-1:0]           out_ready_mask,
  output logic [RS_SIZE-1:0]           out_insert,
  // to the alu
  output alu_uop_pkg::alu_uop_t        out_issue_uop,
  output logic                         out_full
);

  localparam int RS_IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;
  localparam int UOP_W = $bits(alu_uop_pkg::alu_uop_t);

  // slot storage, only the valid bits are control state
  alu_uop_pkg::rs_entry_t entries_q [RS_SIZE];

  logic [RS_SIZE-1:0]    slot_valid;
  logic [RS_IDX_W-1:0]   free_idx;
  logic                  free_found;
  logic                  insert_ok;
  alu_uop_pkg::alu_uop_t disp_uop;
  logic [UOP_W-1:0]      issue_bits;

  // capture a broadcast value into a waiting operand
  // alu source wins when both carry the same tag
  function automatic alu_uop_pkg::operand_t wake(
    input alu_uop_pkg::operand_t   op,
    input rob_tag_pkg::rob_bcast_t rob_b,
    input rob_tag_pkg::rob_bcast_t alu_b
  );
    alu_uop_pkg::operand_t res;
    res = op;
    if (!op.ready) begin
      if (alu_b.valid && (alu_b.tag == op.tag)) begin
        res.ready = 1'b1;
        res.value = alu_b.value;
      end else if (rob_b.valid && (rob_b.tag == op.tag)) begin
        res.ready = 1'b1;
        res.value = rob_b.value;
      end
    end
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      slot_valid[i] = entries_q[i].valid;
      // ready from stored state only, no same-cycle wakeup path
      out_ready_mask[i] = entries_q[i].valid & entries_q[i].uop.op1.ready &
                          entries_q[i].uop.op2.ready;
    end
  end

  assign out_full = &slot_valid;

  // lowest free slot, scanned from the top so the last hit is the lowest
  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    for (int i = RS_SIZE - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_idx   = RS_IDX_W'(i);
        free_found = 1'b1;
      end
    end
  end

  // flush beats dispatch
  assign insert_ok = in_dispatch_valid & free_found & ~in_flush;

  // one-hot insert event, also tells the select about the new age
  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      out_insert[i] = insert_ok && (free_idx == RS_IDX_W'(i));
    end
  end

  // same-cycle bypass for the incoming micro-op
  always_comb begin
    disp_uop     = in_dispatch;
    disp_uop.op1 = wake(in_dispatch.op1, in_rob_bcast, in_alu_bcast);
    disp_uop.op2 = wake(in_dispatch.op2, in_rob_bcast, in_alu_bcast);
  end

  // and-or mux of the granted slot
  always_comb begin
    issue_bits = '0;
    for (int i = 0; i < RS_SIZE; i++) begin
      issue_bits = issue_bits | (entries_q[i].uop & {UOP_W{in_grant[i]}});
    end
  end

  assign out_issue_uop = alu_uop_pkg::alu_uop_t'(issue_bits);

  always_ff @(posedge in_clk) begin
    if (in_rst || in_flush) begin
      for (int i = 0; i < RS_SIZE; i++) begin
        entries_q[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < RS_SIZE; i++) begin
        if (out_insert[i]) begin
          // slot was free, so no grant can hit it this cycle
          entries_q[i].valid <= 1'b1;
          entries_q[i].uop   <= disp_uop;
        end else if (in_grant_valid && in_grant[i]) begin
          // issued, alu takes the payload at this edge
          entries_q[i].valid <= 1'b0;
        end else if (entries_q[i].valid) begin
          entries_q[i].uop.op1 <= wake(entries_q[i].uop.op1, in_rob_bcast, in_alu_bcast);
          entries_q[i].uop.op2 <= wake(entries_q[i].uop.op2, in_rob_bcast, in_alu_bcast);
        end
      end
    end
  end

endmodule : reservation_station

`default_nettype wire

// ==== logic/age_issue_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module age_issue_select #(
  parameter int RS_SIZE = 8
) (
  input  wire logic               in_clk,
  input  wire logic               in_rst,
  // one-hot slot written by the station this cycle
  input  wire logic [RS_SIZE-1:0] in_insert,
  input  wire logic [RS_SIZE-1:0] in_ready_mask,
  input  wire logic               in_fu_ready,
  input  wire logic               in_flush,
  output logic [RS_SIZE-1:0]      out_grant,
  output logic                    out_grant_valid
);

  // older_q[i][j] set means slot j entered before slot i
  logic [RS_SIZE-1:0][RS_SIZE-1:0] older_q;

  // new row says every other slot is older
  // free slots never matter, the grant only looks at ready (valid) slots
  // the new slot's column is cleared so it is older than nobody
  always_ff @(posedge in_clk) begin
    if (in_rst || in_flush) begin
      older_q <= '0;
    end else if (|in_insert) begin
      for (int i = 0; i < RS_SIZE; i++) begin
        if (in_insert[i]) begin
          older_q[i] <= ~in_insert;
        end else begin
          older_q[i] <= older_q[i] & ~in_insert;
        end
      end
    end
  end

  // oldest ready slot, no other ready slot is older than it
  // issue leaves the row alone, the next insert rewrites it
  always_comb begin
    for (int i = 0; i < RS_SIZE; i++) begin
      out_grant[i] = in_fu_ready & in_ready_mask[i] & ~|(older_q[i] & in_ready_mask);
    end
  end

  assign out_grant_valid = |out_grant;

endmodule : age_issue_select

`default_nettype wire

// ==== logic/alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
  input  wire logic                  in_clk,
  input  wire logic                  in_rst,
  input  wire logic                  in_issue_valid,
  input  wire alu_uop_pkg::alu_uop_t in_uop,
  input  wire logic                  in_flush,
  output alu_uop_pkg::alu_result_t   out_result,
  output rob_tag_pkg::rob_bcast_t    out_bcast
);

  localparam int W = rob_tag_pkg::DATA_W;

  logic [W-1:0]          a;
  logic [W-1:0]          b;
  logic [W:0]            sum;
  logic [W-1:0]          res;
  logic                  flag_c;
  logic                  flag_v;
  logic                  res_valid_q;
  rob_tag_pkg::rob_tag_t tag_q;
  logic [W-1:0]          value_q;
  logic                  nzcv_valid_q;
  logic [3:0]            nzcv_q;

  assign a = in_uop.op1.value;
  assign b = in_uop.op2.value;

  always_comb begin
    sum    = '0;
    res    = '0;
    flag_c = 1'b0;
    flag_v = 1'b0;
    unique case (in_uop.opcode)
      alu_uop_pkg::OP_ADD: begin
        sum    = {1'b0, a} + {1'b0, b};
        res    = sum[W-1:0];
        flag_c = sum[W];
        // same operand signs, result sign flipped
        flag_v = (a[W-1] == b[W-1]) && (res[W-1] != a[W-1]);
      end
      alu_uop_pkg::OP_SUB: begin
        // a + ~b + 1, carry out is not-borrow
        sum    = {1'b0, a} + {1'b0, ~b} + {{W{1'b0}}, 1'b1};
        res    = sum[W-1:0];
        flag_c = sum[W];
        flag_v = (a[W-1] != b[W-1]) && (res[W-1] != a[W-1]);
      end
      alu_uop_pkg::OP_AND: res = a & b;
      alu_uop_pkg::OP_ORR: res = a | b;
      alu_uop_pkg::OP_EOR: res = a ^ b;
      alu_uop_pkg::OP_MOV: res = b;
      default: res = '0;
    endcase
  end

  // flush kills the result of the same edge
  always_ff @(posedge in_clk) begin
    if (in_rst || in_flush) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= in_issue_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (in_issue_valid) begin
      tag_q        <= in_uop.dst_tag;
      value_q      <= res;
      nzcv_valid_q <= in_uop.set_nzcv;
      nzcv_q       <= {res[W-1], (res == '0), flag_c, flag_v};
    end
  end

  assign out_result = '{
    valid:      res_valid_q,
    tag:        tag_q,
    value:      value_q,
    nzcv_valid: nzcv_valid_q,
    nzcv:       nzcv_q
  };

  // same registered result fed back for wakeup
  assign out_bcast = '{valid: res_valid_q, tag: tag_q, value: value_q};

endmodule : alu_exec

`default_nettype wire

// ==== logic/int_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_defaults.svh"

module int_issue_top #(
  parameter int RS_SIZE = `RS_SIZE_DEFAULT
) (
  input  wire logic                    in_clk,
  input  wire logic                    in_rst,
  input  wire logic                    in_dispatch_valid,
  input  wire alu_uop_pkg::alu_uop_t   in_dispatch,
  input  wire rob_tag_pkg::rob_bcast_t in_rob_bcast,
  input  wire logic                    in_flush,
  input  wire logic                    in_fu_ready,
  output logic                         out_full,
  output alu_uop_pkg::alu_result_t     out_result
);

  logic [RS_SIZE-1:0]      ready_mask;
  logic [RS_SIZE-1:0]      insert;
  logic [RS_SIZE-1:0]      grant;
  logic                    grant_valid;
  alu_uop_pkg::alu_uop_t   issue_uop;
  // alu result looped back as the second wakeup source
  rob_tag_pkg::rob_bcast_t alu_bcast;

  reservation_station #(
    .RS_SIZE(RS_SIZE)
  ) u_station (
    .in_clk           (in_clk),
    .in_rst           (in_rst),
    .in_dispatch_valid(in_dispatch_valid),
    .in_dispatch      (in_dispatch),
    .in_rob_bcast     (in_rob_bcast),
    .in_alu_bcast     (alu_bcast),
    .in_flush         (in_flush),
    .in_grant         (grant),
    .in_grant_valid   (grant_valid),
    .out_ready_mask   (ready_mask),
    .out_insert       (insert),
    .out_issue_uop    (issue_uop),
    .out_full         (out_full)
  );

  age_issue_select #(
    .RS_SIZE(RS_SIZE)
  ) u_select (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .in_insert      (insert),
    .in_ready_mask  (ready_mask),
    .in_fu_ready    (in_fu_ready),
    .in_flush       (in_flush),
    .out_grant      (grant),
    .out_grant_valid(grant_valid)
  );

  alu_exec u_alu (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .in_issue_valid(grant_valid),
    .in_uop        (issue_uop),
    .in_flush      (in_flush),
    .out_result    (out_result),
    .out_bcast     (alu_bcast)
  );

endmodule : int_issue_top

`default_nettype wire

// ==== dv/int_issue_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_invariants #(
  parameter int RS_SIZE = 8
) (
  input wire logic               in_clk,
  input wire logic               in_rst,
  input wire logic               flush,
  input wire logic               fu_ready,
  input wire logic [RS_SIZE-1:0] grant,
  // valid-and-ready slots of the station
  input wire logic [RS_SIZE-1:0] ready_mask,
  input wire logic               dispatch_valid,
  input wire logic               full,
  // per-slot valid bits of the station
  input wire logic [RS_SIZE-1:0] occupied
);

  // at most one slot issues per cycle
  grant_onehot: assert property (@(posedge in_clk) disable iff (in_rst)
    $onehot0(grant)) else $error("grant vector has more than one bit set");

  // functional unit busy means no issue, every ready entry is still there next cycle
  hold_without_fu: assert property (@(posedge in_clk) disable iff (in_rst)
    (!fu_ready && !flush) |=> ((ready_mask & $past(ready_mask)) == $past(ready_mask)))
    else $error("ready entry left the station while fu_ready was low");

  // dispatch into a full station would drop the micro-op
  no_dispatch_full: assert property (@(posedge in_clk) disable iff (in_rst)
    dispatch_valid |-> !full) else $error("dispatch while the station is full");

  // flush empties every slot at its edge
  empty_after_flush: assert property (@(posedge in_clk) disable iff (in_rst)
    flush |=> (occupied == '0)) else $error("station not empty after flush");

endmodule : issue_invariants

// station side, fu_ready is not visible here so it is tied high
bind reservation_station issue_invariants #(.RS_SIZE(RS_SIZE)) station_checks (
  .in_clk(in_clk), .in_rst(in_rst), .flush(in_flush), .fu_ready(1'b1),
  .grant(in_grant), .ready_mask(out_ready_mask), .dispatch_valid(in_dispatch_valid),
  .full(out_full), .occupied(slot_valid)
);

// select side, no dispatch or occupancy view
bind age_issue_select issue_invariants #(.RS_SIZE(RS_SIZE)) select_checks (
  .in_clk(in_clk), .in_rst(in_rst), .flush(in_flush), .fu_ready(in_fu_ready),
  .grant(out_grant), .ready_mask(in_ready_mask), .dispatch_valid(1'b0),
  .full(1'b0), .occupied('0)
);

`default_nettype wire

// ==== dv/int_issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_defaults.svh"

module int_issue_tb;

  localparam int RS_SIZE = `RS_SIZE_DEFAULT;
  localparam int NTAGS = 2 ** rob_tag_pkg::ROB_TAG_W;

  logic                     in_clk;
  logic                     in_rst;
  logic                     in_dispatch_valid;
  alu_uop_pkg::alu_uop_t    in_dispatch;
  rob_tag_pkg::rob_bcast_t  in_rob_bcast;
  logic                     in_flush;
  logic                     in_fu_ready;
  logic                     out_full;
  alu_uop_pkg::alu_result_t out_result;

  // expectations of the running test, indexed by destination tag
  rob_tag_pkg::reg_value_t exp_value [NTAGS];
  logic                    exp_nzcv_v [NTAGS];
  logic [3:0]              exp_nzcv [NTAGS];
  logic                    exp_valid [NTAGS];
  logic                    seen [NTAGS];
  logic                    forbidden [NTAGS];
  int                      exp_order [NTAGS];
  int                      exp_cnt;
  int                      got_cnt;
  int                      order_mode;
  int                      last_cycle;
  int                      cycle = 0;
  int                      limit = 100000;
  int                      err_cnt = 0;
  int                      check_cnt = 0;
  // levels applied on the next driven cycle
  logic                    fu_level;
  rob_tag_pkg::rob_bcast_t bcast_next;
  // fu_ready as the DUT saw it at the last edge, the issue edge of a visible result
  logic                    fu_at_issue;

  int_issue_top #(
    .RS_SIZE(RS_SIZE)
  ) DUT (
    .in_clk           (in_clk),
    .in_rst           (in_rst),
    .in_dispatch_valid(in_dispatch_valid),
    .in_dispatch      (in_dispatch),
    .in_rob_bcast     (in_rob_bcast),
    .in_flush         (in_flush),
    .in_fu_ready      (in_fu_ready),
    .out_full         (out_full),
    .out_result       (out_result)
  );

  initial begin
    in_clk = 1'b0;
    forever #2 in_clk = ~in_clk;
  end

  // cycle count, also the run limit
  always @(posedge in_clk) begin
    cycle = cycle + 1;
    if (cycle > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TB FAILED");
      $finish;
    end
  end

  always @(posedge in_clk) begin
    fu_at_issue <= in_fu_ready;
  end

  function automatic alu_uop_pkg::operand_t make_operand(
    input logic [31:0] rdy,
    input logic [31:0] tag,
    input logic [31:0] value
  );
    alu_uop_pkg::operand_t op;
    op.ready = rdy[0];
    op.tag   = tag[rob_tag_pkg::ROB_TAG_W-1:0];
    op.value = value;
    return op;
  endfunction

  // one clock of stimulus, pending broadcast rides along once
  task automatic drive_cycle(input logic dv, input alu_uop_pkg::alu_uop_t uop, input logic fl);
    @(posedge in_clk);
    in_dispatch_valid <= dv;
    in_dispatch       <= uop;
    in_flush          <= fl;
    in_fu_ready       <= fu_level;
    in_rob_bcast      <= bcast_next;
    bcast_next = '0;
  endtask

  task automatic clear_expectations();
    for (int i = 0; i < NTAGS; i++) begin
      exp_valid[i] = 1'b0;
      seen[i]      = 1'b0;
      forbidden[i] = 1'b0;
    end
    exp_cnt = 0;
    got_cnt = 0;
  endtask

  // results sampled mid-cycle, away from the driving edge
  always @(negedge in_clk) begin : check_results
    rob_tag_pkg::rob_tag_t t;
    if (!in_rst && out_result.valid === 1'b1) begin
      t = out_result.tag;
      check_cnt++;
      assert (!forbidden[t]) else begin
        $display("flushed micro-op with tag %h still produced a result", t);
        err_cnt++;
      end
      // a busy functional unit takes nothing
      assert (fu_at_issue) else begin
        $display("result for tag %h issued while fu_ready was low", t);
        err_cnt++;
      end
      if (!exp_valid[t] || seen[t]) begin
        assert (forbidden[t]) else begin
          $display("result for tag %h was not expected or came twice", t);
          err_cnt++;
        end
      end else begin
        assert (out_result.value == exp_value[t]) else begin
          $display("Error out_result.value tag %h: expected %h, got %h",
                   t, exp_value[t], out_result.value);
          err_cnt++;
        end
        assert (out_result.nzcv_valid == exp_nzcv_v[t]) else begin
          $display("Error out_result.nzcv_valid tag %h: expected %h, got %h",
                   t, exp_nzcv_v[t], out_result.nzcv_valid);
          err_cnt++;
        end
        // flag bits only matter when the op asked for them
        if (exp_nzcv_v[t]) begin
          assert (out_result.nzcv == exp_nzcv[t]) else begin
            $display("Error out_result.nzcv tag %h: expected %h, got %h",
                     t, exp_nzcv[t], out_result.nzcv);
            err_cnt++;
          end
        end
        if (order_mode != 0) begin
          assert (t == exp_order[got_cnt]) else begin
            $display("Error out_result.tag: expected %h, got %h", exp_order[got_cnt], t);
            err_cnt++;
          end
        end
        if (order_mode == 2 && got_cnt > 0) begin
          assert (cycle == last_cycle + 1) else begin
            $display("result for tag %h did not follow the previous one directly", t);
            err_cnt++;
          end
        end
        seen[t] = 1'b1;
        got_cnt++;
      end
      last_cycle = cycle;
    end
  end

  initial begin
    int                    fd;
    int                    code;
    int                    nrec;
    int                    n;
    int                    test_id;
    int                    test_err;
    int                    ntests;
    logic                  done;
    string                 kind;
    string                 line;
    logic [31:0]           fld [9];
    alu_uop_pkg::alu_uop_t uop;
    in_rst            = 1'b1;
    in_dispatch_valid = 1'b0;
    in_dispatch       = '0;
    in_rob_bcast      = '0;
    in_flush          = 1'b0;
    in_fu_ready       = 1'b0;
    fu_level          = 1'b1;
    bcast_next        = '0;
    order_mode        = 0;
    last_cycle        = 0;
    ntests            = 0;
    test_id           = 0;
    test_err          = 0;
    nrec              = 0;
    clear_expectations();
    fd = $fopen("dv/int_issue_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/int_issue_testdata.txt");
      err_cnt++;
    end else begin
      // first pass counts records for the cycle limit
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          nrec++;
        end
      end
      $fclose(fd);
      limit = nrec * 8 + 200;
      fd = $fopen("dv/int_issue_testdata.txt", "r");
      repeat (16) @(posedge in_clk);
      in_rst <= 1'b0;
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, "%s", kind);
        if (code != 1) begin
          done = 1'b1;
        end else if (kind == "#") begin
          code = $fgets(line, fd);
        end else if (kind == "T") begin
          code = $fscanf(fd, "%d %d", test_id, order_mode);
          clear_expectations();
          test_err = err_cnt;
          ntests++;
        end else if (kind == "E") begin
          code = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
          exp_valid[fld[0][3:0]]  = 1'b1;
          exp_value[fld[0][3:0]]  = fld[1];
          exp_nzcv_v[fld[0][3:0]] = fld[2][0];
          exp_nzcv[fld[0][3:0]]   = fld[3][3:0];
          exp_order[exp_cnt]      = fld[0][3:0];
          exp_cnt++;
        end else if (kind == "X") begin
          code = $fscanf(fd, "%h %h", fld[0], fld[1]);
          for (int i = fld[0]; i <= fld[1]; i++) begin
            forbidden[i] = 1'b1;
          end
        end else if (kind == "R") begin
          code = $fscanf(fd, "%h", fld[0]);
          fu_level = fld[0][0];
        end else if (kind == "B") begin
          code = $fscanf(fd, "%h %h", fld[0], fld[1]);
          bcast_next = '{valid: 1'b1, tag: fld[0][3:0], value: fld[1]};
        end else if (kind == "D") begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                         fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
          uop.opcode   = alu_uop_pkg::alu_op_e'(fld[0][2:0]);
          uop.dst_tag  = fld[1][3:0];
          uop.set_nzcv = fld[2][0];
          uop.op1      = make_operand(fld[3], fld[4], fld[5]);
          uop.op2      = make_operand(fld[6], fld[7], fld[8]);
          drive_cycle(1'b1, uop, 1'b0);
        end else if (kind == "F") begin
          drive_cycle(1'b0, '0, 1'b1);
        end else if (kind == "I") begin
          code = $fscanf(fd, "%d", n);
          repeat (n) drive_cycle(1'b0, '0, 1'b0);
        end else if (kind == "C") begin
          code = $fscanf(fd, "%h", fld[0]);
          @(negedge in_clk);
          assert (out_full == fld[0][0]) else begin
            $display("Error out_full: expected %h, got %h", fld[0][0], out_full);
            err_cnt++;
          end
        end else if (kind == "W") begin
          // wait for every expected result, then a little slack for strays
          while (got_cnt < exp_cnt) begin
            drive_cycle(1'b0, '0, 1'b0);
          end
          repeat (2) drive_cycle(1'b0, '0, 1'b0);
          $display("test %0d: %0d results, %0d errors", test_id, got_cnt, err_cnt - test_err);
        end else begin
          $display("unknown record kind %s in the testdata file", kind);
          err_cnt++;
          done = 1'b1;
        end
      end
      $fclose(fd);
    end
    $display("summary: %0d tests, %0d results checked, %0d errors", ntests, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : int_issue_tb

`default_nettype wire

// ==== sources.f ====
+incdir+include
logic/rob_tag_pkg.sv
logic/alu_uop_pkg.sv
logic/reservation_station.sv
logic/age_issue_select.sv
logic/alu_exec.sv
logic/int_issue_top.sv
dv/int_issue_assertions.sv
dv/int_issue_tb.sv

// ==== Bender.yml ====
package:
  name: int_issue

sources:
  - include_dirs:
      - include
    files:
      - logic/rob_tag_pkg.sv
      - logic/alu_uop_pkg.sv
      - logic/reservation_station.sv
      - logic/age_issue_select.sv
      - logic/alu_exec.sv
      - logic/int_issue_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/int_issue_assertions.sv
      - dv/int_issue_tb.sv

// ==== dv/int_issue_testdata.txt ====
# T id order(0 any 1 in order 2 back to back) | E tag value nzcv_valid nzcv | X lo hi
# D op dst set r1 t1 v1 r2 t2 v2 (op 0 add 1 sub 2 and 3 orr 4 eor 5 mov) | B tag value
# R fu_ready | I cycles | F flush | C out_full | W wait for results
T 1 1
E 1 80000000 1 9
E 2 00000000 1 6
E 3 fffffffe 1 8
E 4 f000f000 1 8
E 5 00000000 0 0
E 6 80000001 1 8
R 1
D 0 1 1 1 0 7fffffff 1 0 00000001
D 1 2 1 1 0 00000005 1 0 00000005
D 1 3 1 1 0 00000003 1 0 00000005
D 2 4 1 1 0 f0f0f0f0 1 0 ff00ff00
D 4 5 0 1 0 12345678 1 0 12345678
D 5 6 1 1 0 00000000 1 0 80000001
W
T 2 1
E 1 00000015 0 0
E 2 00000200 1 2
D 0 1 0 0 c deadbeef 1 0 00000010
I 3
B c 00000005
I 1
B d 00000100
D 1 2 1 1 0 00000300 0 d 00000000
W
T 3 1
E 4 00000030 1 2
E 5 00000028 1 2
E 6 ffffffd7 1 8
D 0 4 1 1 0 ffffffff 1 0 00000031
D 1 5 1 0 4 00000000 1 0 00000008
D 4 6 1 0 5 00000000 1 0 ffffffff
W
T 4 2
E 1 00000002 0 0
E 2 00000007 0 0
E 3 00000101 0 0
E 4 00000000 1 4
R 0
D 0 1 0 1 0 00000001 1 0 00000001
D 1 2 0 1 0 00000009 1 0 00000002
D 3 3 0 1 0 00000100 1 0 00000001
D 5 4 1 1 0 ffffffff 1 0 00000000
I 2
R 1
W
T 5 1
E 9 00000000 1 7
X 1 8
D 0 1 0 0 f 00000000 1 0 00000001
D 0 2 0 0 f 00000000 1 0 00000001
D 0 3 0 0 f 00000000 1 0 00000001
D 0 4 0 0 f 00000000 1 0 00000001
D 0 5 0 0 f 00000000 1 0 00000001
D 0 6 0 0 f 00000000 1 0 00000001
D 0 7 0 0 f 00000000 1 0 00000001
D 0 8 0 0 f 00000000 1 0 00000001
I 1
C 1
F
I 1
C 0
B f 00000001
I 2
D 0 9 1 1 0 80000000 1 0 80000000
W
